// ==== all.f ====
source/isa_pkg.sv
source/track_pkg.sv
source/commit_notif_if.sv
source/seq_num_gen.sv
source/fetch_unit.sv
source/reorder_buffer.sv
source/commit_unit.sv
source/fetch_core_top.sv
testbench/tb_fetch_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f all.f \
  --top-module tb_fetch_core \
  -Mdir obj_dir -o sim_fetch_core

./obj_dir/sim_fetch_core > sim.log
cat sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
  exit 0
fi
exit 1

// ==== source/commit_notif_if.sv ====
// ---------------------------------------------------------------------------
// Commit notification
// One in-order commit per cycle, consumed when valid, no ready
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

interface commit_notif_if
  import isa_pkg::*;
  import track_pkg::*;
();

  logic      val;
  seq_num_t  seq_num;
  pc_t       pc;
  reg_addr_t waddr;
  word_t     wdata;
  logic      wen;

  // Commit unit side
  modport pub (output val, seq_num, pc, waddr, wdata, wen);

  // Listener side, e.g. the tag allocator
  modport sub (input val, seq_num, pc, waddr, wdata, wen);

endinterface

`default_nettype wire

// ==== source/commit_unit.sv ====
// ---------------------------------------------------------------------------
// Commit unit
// Retires ROB entries strictly in tag order, one per cycle, and
// publishes each commit
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module commit_unit
  import isa_pkg::*;
  import track_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,

  // ROB head
  output seq_num_t         head_seq_num,
  input  wire logic        head_done,
  input  wire pc_t         head_pc,
  input  wire result_pkt_t head_res,
  output logic             retire_en,

  // Commit notification out
  commit_notif_if.pub      commit
);

  // Oldest uncommitted tag
  seq_num_t commit_ptr_q;

  assign head_seq_num = commit_ptr_q;

  // Commit as soon as the oldest entry is done
  assign retire_en = head_done;

  assign commit.val     = head_done;
  assign commit.seq_num = commit_ptr_q;
  assign commit.pc      = head_pc;
  assign commit.waddr   = head_res.waddr;
  assign commit.wdata   = head_res.wdata;
  assign commit.wen     = head_res.wen;

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_ptr_q <= '0;
    end else if (retire_en) begin
      commit_ptr_q <= commit_ptr_q + seq_num_t'(1);
    end
  end

endmodule

`default_nettype wire

// ==== source/fetch_core_top.sv ====
// ---------------------------------------------------------------------------
// Fetch core top level
// Tag allocator, fetch, reorder buffer and commit, with plain ports
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fetch_core_top
  import isa_pkg::*;
  import track_pkg::*;
#(
  parameter pc_t p_reset_pc      = '0,
  parameter int  p_reclaim_width = 2
) (
  input  wire logic      clk,
  input  wire logic      rst,

  // Instruction issue
  output logic           inst_val,
  input  wire logic      inst_rdy,
  output pc_t            inst_pc,
  output seq_num_t       inst_seq_num,

  // Results, always accepted
  input  wire logic      res_val,
  input  wire seq_num_t  res_seq_num,
  input  wire reg_addr_t res_waddr,
  input  wire word_t     res_wdata,
  input  wire logic      res_wen,

  // In-order commits
  output logic           commit_val,
  output seq_num_t       commit_seq_num,
  output pc_t            commit_pc,
  output reg_addr_t      commit_waddr,
  output word_t          commit_wdata,
  output logic           commit_wen
);

  // Allocation handshake
  logic        alloc_val;
  seq_num_t    alloc_seq_num;
  logic        alloc_rdy;

  // Issue into the ROB
  logic        issue_en;
  seq_num_t    issue_seq_num;
  pc_t         issue_pc;

  // ROB head to commit
  seq_num_t    head_seq_num;
  logic        head_done;
  pc_t         head_pc;
  result_pkt_t head_res;
  logic        retire_en;

  result_pkt_t res_pkt;

  commit_notif_if commit_if ();

  assign res_pkt = '{waddr: res_waddr, wdata: res_wdata, wen: res_wen};

  seq_num_gen #(
    .p_reclaim_width (p_reclaim_width)
  ) u_seq_num_gen (
    .clk           (clk),
    .rst           (rst),
    .alloc_val     (alloc_val),
    .alloc_seq_num (alloc_seq_num),
    .alloc_rdy     (alloc_rdy),
    .commit        (commit_if.sub)
  );

  fetch_unit #(
    .p_reset_pc (p_reset_pc)
  ) u_fetch_unit (
    .clk           (clk),
    .rst           (rst),
    .alloc_val     (alloc_val),
    .alloc_seq_num (alloc_seq_num),
    .alloc_rdy     (alloc_rdy),
    .inst_val      (inst_val),
    .inst_pc       (inst_pc),
    .inst_seq_num  (inst_seq_num),
    .inst_rdy      (inst_rdy),
    .issue_en      (issue_en),
    .issue_seq_num (issue_seq_num),
    .issue_pc      (issue_pc)
  );

  reorder_buffer u_reorder_buffer (
    .clk           (clk),
    .rst           (rst),
    .issue_en      (issue_en),
    .issue_seq_num (issue_seq_num),
    .issue_pc      (issue_pc),
    .res_val       (res_val),
    .res_seq_num   (res_seq_num),
    .res           (res_pkt),
    .head_seq_num  (head_seq_num),
    .head_done     (head_done),
    .head_pc       (head_pc),
    .head_res      (head_res),
    .retire_en     (retire_en)
  );

  commit_unit u_commit_unit (
    .clk          (clk),
    .rst          (rst),
    .head_seq_num (head_seq_num),
    .head_done    (head_done),
    .head_pc      (head_pc),
    .head_res     (head_res),
    .retire_en    (retire_en),
    .commit       (commit_if.pub)
  );

  // Commit group out as plain ports
  assign commit_val     = commit_if.val;
  assign commit_seq_num = commit_if.seq_num;
  assign commit_pc      = commit_if.pc;
  assign commit_waddr   = commit_if.waddr;
  assign commit_wdata   = commit_if.wdata;
  assign commit_wen     = commit_if.wen;

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
// ---------------------------------------------------------------------------
// Fetch unit
// Steps the PC, pairs it with a tag and records each issue in the ROB
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fetch_unit
  import isa_pkg::*;
  import track_pkg::*;
#(
  parameter pc_t p_reset_pc = '0
) (
  input  wire logic     clk,
  input  wire logic     rst,

  // Tag offered by the allocator
  input  wire logic     alloc_val,
  input  wire seq_num_t alloc_seq_num,
  output logic          alloc_rdy,

  // Issue stream out of the core
  output logic          inst_val,
  output pc_t           inst_pc,
  output seq_num_t      inst_seq_num,
  input  wire logic     inst_rdy,

  // ROB write on issue
  output logic          issue_en,
  output seq_num_t      issue_seq_num,
  output pc_t           issue_pc
);

  pc_t  pc_q;
  logic xfer;

  // Valid follows the allocator with no added latency
  assign inst_val     = alloc_val;
  assign inst_pc      = pc_q;
  assign inst_seq_num = alloc_seq_num;
  assign alloc_rdy    = inst_rdy;
  assign xfer         = alloc_val && inst_rdy;

  // Record the pair in the ROB at the transfer edge
  assign issue_en      = xfer;
  assign issue_seq_num = alloc_seq_num;
  assign issue_pc      = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= p_reset_pc;
    end else if (xfer) begin
      pc_q <= pc_q + pc_t'(INST_BYTES);
    end
  end

  // Allocator keeps offering the same tag while issue is stalled
  a_stall_hold: assert property (
    @(posedge clk) disable iff (rst)
    (inst_val && !inst_rdy) |=> $stable(inst_seq_num)
  );

endmodule

`default_nettype wire

// ==== source/isa_pkg.sv ====
// ---------------------------------------------------------------------------
// ISA types
// Architectural widths for PCs, register indices and data words
// ---------------------------------------------------------------------------

`default_nettype none

package isa_pkg;

  // Instruction address
  typedef logic [31:0] pc_t;

  // Register data word
  typedef logic [31:0] word_t;

  // Register file index, 32 registers
  typedef logic [4:0] reg_addr_t;

  // Fixed instruction size, PC step per fetch
  localparam int INST_BYTES = 4;

endpackage

`default_nettype wire

// ==== source/reorder_buffer.sv ====
// ---------------------------------------------------------------------------
// Reorder buffer
// One entry per tag with PC, result and pending and done flags;
// results arrive in any order, the head is read for commit
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
  import isa_pkg::*;
  import track_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,

  // Issue from fetch
  input  wire logic        issue_en,
  input  wire seq_num_t    issue_seq_num,
  input  wire pc_t         issue_pc,

  // Results from execution, any order
  input  wire logic        res_val,
  input  wire seq_num_t    res_seq_num,
  input  wire result_pkt_t res,

  // Head read for commit
  input  wire seq_num_t    head_seq_num,
  output logic             head_done,
  output pc_t              head_pc,
  output result_pkt_t      head_res,
  input  wire logic        retire_en
);

  // -------------------------------------------------------------------------
  // Entry storage
  // -------------------------------------------------------------------------

  // Control flags
  logic [NUM_SEQ_NUMS-1:0] pending_q;
  logic [NUM_SEQ_NUMS-1:0] done_q;

  // Payload
  pc_t         pc_mem  [NUM_SEQ_NUMS];
  result_pkt_t res_mem [NUM_SEQ_NUMS];

  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= '0;
      done_q    <= '0;
    end else begin
      // Retire, issue and result never hit the same entry in one cycle
      if (retire_en) begin
        pending_q[head_seq_num] <= 1'b0;
        done_q[head_seq_num]    <= 1'b0;
      end
      if (issue_en) begin
        pending_q[issue_seq_num] <= 1'b1;
      end
      if (res_val) begin
        done_q[res_seq_num] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue_en) begin
      pc_mem[issue_seq_num] <= issue_pc;
    end
    if (res_val) begin
      res_mem[res_seq_num] <= res;
    end
  end

  // Head entry, combinational read
  assign head_done = done_q[head_seq_num];
  assign head_pc   = pc_mem[head_seq_num];
  assign head_res  = res_mem[head_seq_num];

  // -------------------------------------------------------------------------
  // Checks
  // -------------------------------------------------------------------------

  // Results only for issued, still unfinished entries
  a_res_pending: assert property (
    @(posedge clk) disable iff (rst)
    res_val |-> (pending_q[res_seq_num] && !done_q[res_seq_num])
  );

  // Allocator never reuses a live tag
  a_issue_free: assert property (
    @(posedge clk) disable iff (rst)
    issue_en |-> !pending_q[issue_seq_num]
  );

endmodule

`default_nettype wire

// ==== source/seq_num_gen.sv ====
// ---------------------------------------------------------------------------
// Sequence number generator
// Hands out tags in order, frees them on commit notifications and
// reclaims freed tags at the tail, a few per cycle
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module seq_num_gen
  import track_pkg::*;
#(
  parameter int p_reclaim_width = 2
) (
  input  wire logic     clk,
  input  wire logic     rst,

  // Allocation handshake
  output logic          alloc_val,
  output seq_num_t      alloc_seq_num,
  input  wire logic     alloc_rdy,

  // Commits free tags
  commit_notif_if.sub   commit
);

  // -------------------------------------------------------------------------
  // Tag state
  // -------------------------------------------------------------------------

  // One bit per tag, set while the tag is live
  logic [NUM_SEQ_NUMS-1:0] alloc_q;

  // Next tag to hand out
  seq_num_t head_q;
  // Oldest tag not yet reclaimed
  seq_num_t tail_q;

  logic     alloc_xfer;
  seq_num_t in_use;
  seq_num_t reclaim_cnt;

  // Full when head sits one behind tail
  assign alloc_val     = (head_q + seq_num_t'(1)) != tail_q;
  assign alloc_seq_num = head_q;
  assign alloc_xfer    = alloc_val && alloc_rdy;

  // Tags between tail and head
  assign in_use = head_q - tail_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      alloc_q <= '0;
      head_q  <= '0;
    end else begin
      if (alloc_xfer) begin
        alloc_q[head_q] <= 1'b1;
        head_q          <= head_q + seq_num_t'(1);
      end
      // Commit frees its tag at the commit edge
      if (commit.val) begin
        alloc_q[commit.seq_num] <= 1'b0;
      end
    end
  end

  // -------------------------------------------------------------------------
  // Tail reclaim
  // -------------------------------------------------------------------------

  // Longest run of freed tags from the tail, capped at the reclaim width
  always_comb begin
    seq_num_t idx;
    logic     run_open;
    reclaim_cnt = '0;
    run_open    = 1'b1;
    for (int i = 0; i < p_reclaim_width; i++) begin
      idx = tail_q + seq_num_t'(i);
      // Only tags inside the live range count
      if (run_open && !alloc_q[idx] && (seq_num_t'(i) < in_use)) begin
        reclaim_cnt = seq_num_t'(i + 1);
      end else begin
        run_open = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tail_q <= '0;
    end else begin
      tail_q <= tail_q + reclaim_cnt;
    end
  end

  // Commit unit only ever retires a tag handed out here
  a_commit_allocated: assert property (
    @(posedge clk) disable iff (rst)
    commit.val |-> alloc_q[commit.seq_num]
  );

endmodule

`default_nettype wire

// ==== source/track_pkg.sv ====
// ---------------------------------------------------------------------------
// Instruction tracking types
// Sequence number tags and the executed result packet
// ---------------------------------------------------------------------------

`default_nettype none

package track_pkg;

  import isa_pkg::*;

  // Tag width, 32 tags with at most 31 in flight
  localparam int SEQ_NUM_BITS = 5;

  // Number of tags, also the reorder buffer depth
  localparam int NUM_SEQ_NUMS = 2 ** SEQ_NUM_BITS;

  typedef logic [SEQ_NUM_BITS-1:0] seq_num_t;

  // Result returned by execution, 38 bits
  typedef struct packed {
    reg_addr_t waddr;
    word_t     wdata;
    logic      wen;
  } result_pkt_t;

endpackage

`default_nettype wire

// ==== testbench/tb_fetch_core.sv ====
// ---------------------------------------------------------------------------
// Fetch core testbench
// Random issue back-pressure and out-of-order results, with an in-order
// commit model that checks PCs, tags, payloads and capacity
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_fetch_core
  import isa_pkg::*;
  import track_pkg::*;
();

  localparam pc_t p_reset_pc      = 32'h100;
  localparam int  p_reclaim_width = 2;

  localparam int num_commits     = 600;
  localparam int withhold_at     = 200;
  localparam int withhold_cycles = 40;
  localparam int max_in_flight   = NUM_SEQ_NUMS - 1;
  // Worst case about 32 cycles per commit, plus reset and drain
  localparam int timeout_cycles  = num_commits * 32 + 800;

  logic      clk;
  logic      rst;
  logic      inst_val;
  logic      inst_rdy;
  pc_t       inst_pc;
  seq_num_t  inst_seq_num;
  logic      res_val;
  seq_num_t  res_seq_num;
  reg_addr_t res_waddr;
  word_t     res_wdata;
  logic      res_wen;
  logic      commit_val;
  seq_num_t  commit_seq_num;
  pc_t       commit_pc;
  reg_addr_t commit_waddr;
  word_t     commit_wdata;
  logic      commit_wen;

  fetch_core_top #(
    .p_reset_pc      (p_reset_pc),
    .p_reclaim_width (p_reclaim_width)
  ) UUT (
    .clk            (clk),
    .rst            (rst),
    .inst_val       (inst_val),
    .inst_rdy       (inst_rdy),
    .inst_pc        (inst_pc),
    .inst_seq_num   (inst_seq_num),
    .res_val        (res_val),
    .res_seq_num    (res_seq_num),
    .res_waddr      (res_waddr),
    .res_wdata      (res_wdata),
    .res_wen        (res_wen),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .commit_pc      (commit_pc),
    .commit_waddr   (commit_waddr),
    .commit_wdata   (commit_wdata),
    .commit_wen     (commit_wen)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ---------------------------------------------------------------------------
  // Model state
  // ---------------------------------------------------------------------------

  // Issued and not yet committed, oldest first
  seq_num_t  exp_seq_q [$];
  pc_t       exp_pc_q  [$];
  // Issued with no result sent yet
  seq_num_t  out_q     [$];
  // Results sent, by tag
  reg_addr_t sent_waddr [NUM_SEQ_NUMS];
  word_t     sent_wdata [NUM_SEQ_NUMS];
  logic      sent_wen   [NUM_SEQ_NUMS];
  bit        res_sent   [NUM_SEQ_NUMS];

  logic [15:0] lfsr_q;
  int          cycle_cnt      = 0;
  int          issue_cnt      = 0;
  int          commit_cnt     = 0;
  int          value_errs     = 0;
  int          other_errs     = 0;
  int          withhold_left  = 0;
  int          restart_cycles = 0;
  bit          restart_wait   = 1'b0;
  bit          expect_commit  = 1'b0;
  bit          full_seen      = 1'b0;
  bit          timed_out      = 1'b0;
  bit          stall_prev     = 1'b0;
  pc_t         held_pc;
  seq_num_t    held_seq;

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Fail at %0d ns: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
    value_errs++;
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    other_errs++;
  endtask

  // ---------------------------------------------------------------------------
  // One clock cycle: check outputs, then drive inputs, at the falling edge
  // ---------------------------------------------------------------------------

  task automatic run_cycle(input bit issue_on);
    int       in_flight;
    int       idx;
    seq_num_t rseq;
    seq_num_t exp_seq;
    pc_t      exp_pc;
    @(negedge clk);
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles)
      timed_out = 1'b1;
    in_flight = exp_seq_q.size();

    // Capacity, 31 tags at most
    if (inst_val && in_flight >= max_in_flight)
      report_error($sformatf("inst_val high with %0d instructions in flight", in_flight));
    if (!inst_val && in_flight >= max_in_flight)
      full_seen = 1'b1;

    // Stalled issue holds its PC and tag
    if (stall_prev) begin
      if (inst_pc !== held_pc)
        report_mismatch("inst_pc", held_pc, inst_pc);
      if (inst_seq_num !== held_seq)
        report_mismatch("inst_seq_num", 32'(held_seq), 32'(inst_seq_num));
    end

    // Issue restarts soon after a commit from full
    if (restart_wait) begin
      restart_cycles++;
      if (inst_val) begin
        restart_wait = 1'b0;
      end else if (restart_cycles >= 4) begin
        report_error("issue did not restart within 4 cycles of a commit from full");
        restart_wait = 1'b0;
      end
    end

    // Oldest entry got its result last cycle
    if (expect_commit && !commit_val)
      report_error("no commit one cycle after the oldest entry got its result");
    expect_commit = 1'b0;

    if (commit_val) begin
      if (exp_seq_q.size() == 0) begin
        report_error($sformatf("commit of tag %0d with nothing expected", commit_seq_num));
      end else begin
        if (!inst_val && in_flight >= max_in_flight && !restart_wait) begin
          restart_wait   = 1'b1;
          restart_cycles = 0;
        end
        exp_seq = exp_seq_q.pop_front();
        exp_pc  = exp_pc_q.pop_front();
        if (commit_seq_num !== exp_seq)
          report_mismatch("commit_seq_num", 32'(exp_seq), 32'(commit_seq_num));
        if (commit_pc !== exp_pc)
          report_mismatch("commit_pc", exp_pc, commit_pc);
        if (!res_sent[exp_seq]) begin
          report_error($sformatf("tag %0d committed before its result", exp_seq));
        end else begin
          if (commit_waddr !== sent_waddr[exp_seq])
            report_mismatch("commit_waddr", 32'(sent_waddr[exp_seq]), 32'(commit_waddr));
          if (commit_wdata !== sent_wdata[exp_seq])
            report_mismatch("commit_wdata", sent_wdata[exp_seq], commit_wdata);
          if (commit_wen !== sent_wen[exp_seq])
            report_mismatch("commit_wen", 32'(sent_wen[exp_seq]), 32'(commit_wen));
        end
        res_sent[exp_seq] = 1'b0;
      end
      commit_cnt++;
      // Starve the ROB of results to fill it up
      if (commit_cnt == withhold_at)
        withhold_left = withhold_cycles;
    end

    // Issue back-pressure, about 75% ready
    if (!issue_on)
      inst_rdy = 1'b0;
    else if (withhold_left > 0)
      inst_rdy = 1'b1;
    else
      inst_rdy = (rand_bits(2) != 0);

    // Result for a random outstanding entry, picked before this cycle's issue
    res_val     = 1'b0;
    res_seq_num = '0;
    res_waddr   = '0;
    res_wdata   = '0;
    res_wen     = 1'b0;
    if (withhold_left > 0) begin
      withhold_left--;
    end else if (out_q.size() > 0 && (!issue_on || rand_bits(2) != 0)) begin
      idx  = int'(rand_bits(5)) % out_q.size();
      rseq = out_q[idx];
      out_q.delete(idx);
      res_val     = 1'b1;
      res_seq_num = rseq;
      res_waddr   = reg_addr_t'(rand_bits(5));
      res_wdata   = rand_bits(32);
      res_wen     = 1'(rand_bits(1));
      sent_waddr[rseq] = res_waddr;
      sent_wdata[rseq] = res_wdata;
      sent_wen[rseq]   = res_wen;
      res_sent[rseq]   = 1'b1;
      if (rseq == exp_seq_q[0])
        expect_commit = 1'b1;
    end

    // Transfer at the next rising edge, 4 bytes per instruction
    if (inst_val && inst_rdy) begin
      exp_pc  = p_reset_pc + pc_t'(issue_cnt * 4);
      exp_seq = seq_num_t'(issue_cnt);
      if (inst_pc !== exp_pc)
        report_mismatch("inst_pc", exp_pc, inst_pc);
      if (inst_seq_num !== exp_seq)
        report_mismatch("inst_seq_num", 32'(exp_seq), 32'(inst_seq_num));
      exp_seq_q.push_back(exp_seq);
      exp_pc_q.push_back(exp_pc);
      out_q.push_back(exp_seq);
      issue_cnt++;
    end
    stall_prev = inst_val && !inst_rdy;
    held_pc    = inst_pc;
    held_seq   = inst_seq_num;
  endtask

  // ---------------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------------

  initial begin
    rst         = 1'b1;
    inst_rdy    = 1'b0;
    res_val     = 1'b0;
    res_seq_num = '0;
    res_waddr   = '0;
    res_wdata   = '0;
    res_wen     = 1'b0;
    lfsr_q      = 16'd48;

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // State right out of reset
    if (commit_val !== 1'b0)
      report_mismatch("commit_val", 32'h0, 32'(commit_val));
    if (inst_val !== 1'b1)
      report_mismatch("inst_val", 32'h1, 32'(inst_val));

    while (commit_cnt < num_commits && !timed_out)
      run_cycle(1'b1);
    // Stop issue and drain what is left
    while (exp_seq_q.size() > 0 && !timed_out)
      run_cycle(1'b0);
    // Any stray commit shows up here
    repeat (4) run_cycle(1'b0);

    if (timed_out)
      report_error("timeout before all commits");
    if (exp_seq_q.size() > 0)
      report_error($sformatf("%0d issued instructions never committed", exp_seq_q.size()));
    if (!full_seen)
      report_error("reorder buffer never reached 31 instructions in flight");

    $display("issued %0d, committed %0d, value errors %0d, other errors %0d",
             issue_cnt, commit_cnt, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
